// File: all.f
mm_cfg_pkg.sv
mm_ctrl_pkg.sv
mm_ctrl_fsm.sv
mm_beat_counter.sv
mm_skew_lines.sv
mm_pe.sv
mm_pe_array.sv
mm_systolic_top.sv
tb_mm_systolic.sv

// File: mm_beat_counter.sv
// Run beat counter

`timescale 1ns/1ps

module mm_beat_counter
    import mm_ctrl_pkg::*;
(
    input  logic clk,
    input  logic arst_n_i,
    input  logic run_i,
    output logic load_last_o,
    output logic run_last_o
);

    logic [BEAT_W-1:0] count_q;

    // Wraps to zero on the last run beat so the next run starts clean
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (!run_i || run_last_o) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign load_last_o = (count_q == BEAT_W'(K_DEPTH - 1));
    assign run_last_o  = (count_q == BEAT_W'(RUN_BEATS - 1));

    a_count_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        count_q <= BEAT_W'(RUN_BEATS - 1));

endmodule

// File: mm_cfg_pkg.sv
// Systolic array geometry and data types

package mm_cfg_pkg;

    // ======================================================================
    // Geometry and widths
    // ======================================================================

    // Side of the square array, also the number of lanes per bar
    localparam int ARRAY_DIM = 8;

    // Unsigned operand width
    localparam int OPERAND_W = 8;

    // Per-cell sum, wide enough for 128 full-scale products
    localparam int ACC_W = 32;

    // ======================================================================
    // Data types
    // ======================================================================

    typedef logic [OPERAND_W-1:0] operand_t;

    // One bar of operands, lane 0 in the low byte
    typedef operand_t [ARRAY_DIM-1:0] lane_vec_t;

    typedef logic [ACC_W-1:0] acc_t;

    // Sums of one array row, column j at index j
    typedef acc_t [ARRAY_DIM-1:0] result_row_t;

    // Full result, row i at index i
    typedef result_row_t [ARRAY_DIM-1:0] result_mat_t;

endpackage

// File: mm_ctrl_fsm.sv
// Run sequencing FSM

`timescale 1ns/1ps

module mm_ctrl_fsm
    import mm_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  start_i,
    input  logic  load_last_i,
    input  logic  run_last_i,
    output ctrl_t ctrl_o,
    output logic  run_o,
    output logic  busy_o,
    output logic  done_o
);

    run_state_t state_q;
    run_state_t state_d;
    logic       clear_q;
    logic       done_q;

    // Start is only looked at while idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                if (load_last_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (run_last_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            clear_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            clear_q <= (state_q == IDLE) && (state_d == LOAD);
            done_q  <= (state_q == DRAIN) && (state_d == IDLE);
        end
    end

    assign ctrl_o.clear = clear_q;
    assign ctrl_o.load  = (state_q == LOAD);
    assign run_o        = (state_q != IDLE);
    assign busy_o       = (state_q != IDLE);
    assign done_o       = done_q;

    a_done_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |=> !done_o);

    // Clear belongs to the first load cycle only
    a_clear_on_entry: assert property (@(posedge clk) disable iff (!arst_n_i)
        ctrl_o.clear |-> $past(state_q == IDLE) && (state_q == LOAD));

endmodule

// File: mm_ctrl_pkg.sv
// Run control definitions

package mm_ctrl_pkg;

    // ======================================================================
    // Run lengths
    // ======================================================================

    // Inner dimension, one beat per element
    localparam int K_DEPTH = 128;

    // Skew plus pipeline depth to the far corner cell
    localparam int DRAIN_BEATS = 15;

    localparam int RUN_BEATS = K_DEPTH + DRAIN_BEATS;

    localparam int BEAT_W = 8;

    // ======================================================================
    // Run phases and control bundle
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN
    } run_state_t;

    typedef struct packed {
        logic clear;    // one cycle, empties every accumulator
        logic load;     // high across the 128-beat load window
    } ctrl_t;

endpackage

// File: mm_pe.sv
// Multiply-accumulate cell

`timescale 1ns/1ps

module mm_pe
    import mm_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     clear_i,
    input  operand_t a_i,
    input  operand_t b_i,
    output operand_t a_o,
    output operand_t b_o,
    output acc_t     acc_o
);

    logic [2*OPERAND_W-1:0] product;

    // A goes right, B goes down
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
        end
    end

    // Multiply the registered pair, one cycle behind the forwarding stage
    assign product = a_o * b_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_o <= '0;
        end else if (clear_i) begin
            acc_o <= '0;
        end else begin
            acc_o <= acc_o + ACC_W'(product);
        end
    end

    a_acc_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown(acc_o));

endmodule

// File: mm_pe_array.sv
// Output-stationary 8x8 MAC grid

`timescale 1ns/1ps

module mm_pe_array
    import mm_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        clear_i,
    input  lane_vec_t   a_bar_i,
    input  lane_vec_t   b_bar_i,
    output result_mat_t result_o
);

    // Forwarded operands out of every cell; right and bottom edges go unread
    operand_t a_fwd [ARRAY_DIM][ARRAY_DIM];
    operand_t b_fwd [ARRAY_DIM][ARRAY_DIM];

    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
            operand_t a_in;
            operand_t b_in;

            // Left edge takes row lane i
            if (j == 0) begin : g_a_edge
                assign a_in = a_bar_i[i];
            end else begin : g_a_link
                assign a_in = a_fwd[i][j-1];
            end

            // Top edge takes column lane j
            if (i == 0) begin : g_b_edge
                assign b_in = b_bar_i[j];
            end else begin : g_b_link
                assign b_in = b_fwd[i-1][j];
            end

            mm_pe i_pe (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .clear_i  (clear_i),
                .a_i      (a_in),
                .b_i      (b_in),
                .a_o      (a_fwd[i][j]),
                .b_o      (b_fwd[i][j]),
                .acc_o    (result_o[i][j])
            );
        end
    end

endmodule

// File: mm_skew_lines.sv
// Operand bar skew stage

`timescale 1ns/1ps

module mm_skew_lines
    import mm_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      load_i,
    input  lane_vec_t bar_i,
    output lane_vec_t bar_o
);

    lane_vec_t bar_gated;

    // Zeros outside the load window keep idle cycles out of the sums
    assign bar_gated = load_i ? bar_i : '0;

    assign bar_o[0] = bar_gated[0];

    // ======================================================================
    // Lane n runs through n registers
    // ======================================================================

    for (genvar n = 1; n < ARRAY_DIM; n++) begin : g_lane
        operand_t line_q [n];

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                for (int s = 0; s < n; s++) begin
                    line_q[s] <= '0;
                end
            end else begin
                line_q[0] <= bar_gated[n];
                for (int s = 1; s < n; s++) begin
                    line_q[s] <= line_q[s-1];
                end
            end
        end

        assign bar_o[n] = line_q[n-1];
    end

endmodule

// File: mm_systolic_top.sv
// Systolic matrix multiplier top

`timescale 1ns/1ps

module mm_systolic_top
    import mm_cfg_pkg::*;
    import mm_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        start_i,
    input  lane_vec_t   row_bar_i,
    input  lane_vec_t   col_bar_i,
    output logic        busy_o,
    output logic        load_o,
    output logic        done_o,
    output result_mat_t result_o
);

    ctrl_t     ctrl;
    logic      run;
    logic      load_last;
    logic      run_last;
    lane_vec_t row_skewed;
    lane_vec_t col_skewed;

    // ======================================================================
    // Control
    // ======================================================================

    mm_ctrl_fsm i_ctrl_fsm (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .load_last_i (load_last),
        .run_last_i  (run_last),
        .ctrl_o      (ctrl),
        .run_o       (run),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    mm_beat_counter i_beat_counter (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .run_i       (run),
        .load_last_o (load_last),
        .run_last_o  (run_last)
    );

    assign load_o = ctrl.load;

    // ======================================================================
    // Datapath
    // ======================================================================

    mm_skew_lines i_row_skew (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (ctrl.load),
        .bar_i    (row_bar_i),
        .bar_o    (row_skewed)
    );

    mm_skew_lines i_col_skew (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (ctrl.load),
        .bar_i    (col_bar_i),
        .bar_o    (col_skewed)
    );

    mm_pe_array i_pe_array (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clear_i  (ctrl.clear),
        .a_bar_i  (row_skewed),
        .b_bar_i  (col_skewed),
        .result_o (result_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the systolic multiplier testbench with Verilator

LOG=sim.log
TOP=tb_mm_systolic

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module "$TOP" --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_mm_systolic.sv
// Systolic multiplier testbench

`timescale 1ns/1ps

module tb_mm_systolic
    import mm_cfg_pkg::*;
    import mm_ctrl_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_RUNS        = 4;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_BEATS + 20) + 50;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        start_i;
    lane_vec_t   row_bar_i;
    lane_vec_t   col_bar_i;
    logic        busy_o;
    logic        load_o;
    logic        done_o;
    result_mat_t result_o;

    integer      seed = 32'ha3b6f413;

    // A is stored row by row, B column lane by beat
    operand_t    mat_a [ARRAY_DIM][K_DEPTH];
    operand_t    mat_b [K_DEPTH][ARRAY_DIM];
    result_mat_t expected_q [$];
    result_mat_t last_expected = '0;

    int          cycle_cnt    = 0;
    int          start_edge   = 0;
    int          load_cycles  = 0;
    int          runs_checked = 0;
    logic        busy_prev    = 1'b0;

    mm_systolic_top i_dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (start_i),
        .row_bar_i (row_bar_i),
        .col_bar_i (col_bar_i),
        .busy_o    (busy_o),
        .load_o    (load_o),
        .done_o    (done_o),
        .result_o  (result_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Rising edges seen so far
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ======================================================================
    // Reference model and checks
    // ======================================================================

    function automatic result_mat_t ref_product();
        result_mat_t prod;
        acc_t        sum;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                sum = '0;
                for (int k = 0; k < K_DEPTH; k++) begin
                    sum = sum + acc_t'(mat_a[i][k]) * acc_t'(mat_b[k][j]);
                end
                prod[i][j] = sum;
            end
        end
        return prod;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_matrix(input result_mat_t actual, input result_mat_t expected);
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                check_value($sformatf("result_o[%0d][%0d]", i, j), actual[i][j],
                            expected[i][j]);
            end
        end
    endtask

    task automatic fill_operands(input bit full_scale);
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int k = 0; k < K_DEPTH; k++) begin
                mat_a[i][k] = full_scale ? 8'hFF : operand_t'($random(seed));
                mat_b[k][i] = full_scale ? 8'hFF : operand_t'($random(seed));
            end
        end
    endtask

    // Starts right after a rising edge with the DUT idle, returns in the done cycle
    task automatic run_matrix(input bit full_scale, input bit stray_starts);
        int beat;
        int drain;
        beat  = 0;
        drain = 0;
        fill_operands(full_scale);
        expected_q.push_back(ref_product());
        start_i = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        while (load_o) begin
            if (beat == K_DEPTH) begin
                abort_run($sformatf("load_o stayed high for more than %0d cycles", K_DEPTH));
            end
            start_i = stray_starts && (beat == 50);
            for (int n = 0; n < ARRAY_DIM; n++) begin
                row_bar_i[n] = mat_a[n][beat];
                col_bar_i[n] = mat_b[beat][n];
            end
            beat++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        // Junk on the bars while draining must not reach the sums
        while (!done_o) begin
            start_i   = stray_starts && (drain == 6);
            row_bar_i = lane_vec_t'({$random(seed), $random(seed)});
            col_bar_i = lane_vec_t'({$random(seed), $random(seed)});
            drain++;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        start_i = 1'b0;
    endtask

    // ======================================================================
    // Processes
    // ======================================================================

    // Sampled at the falling edge where every output is settled
    initial begin : compare_proc
        forever begin
            @(negedge clk);
            if (done_o) begin
                check_value("done_o latency", cycle_cnt - start_edge, RUN_BEATS);
                check_value("load_o width", load_cycles, K_DEPTH);
                // Busy drops in the same cycle that done rises
                check_value("busy_o before done_o", 32'(busy_prev), 1);
                check_value("busy_o with done_o", 32'(busy_o), 0);
                if (expected_q.size() == 0) begin
                    abort_run("done_o pulsed without a started run");
                end else begin
                    last_expected = expected_q.pop_front();
                    check_matrix(result_o, last_expected);
                    runs_checked++;
                    load_cycles = 0;
                end
            end
            if (load_o) begin
                load_cycles++;
                check_value("busy_o during load", 32'(busy_o), 1);
            end
            if (start_i && !busy_o) begin
                start_edge = cycle_cnt + 1;
            end
            busy_prev = busy_o;
        end
    end

    initial begin : watchdog_proc
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("Timeout after %0d cycles, %0d of %0d runs finished",
                            WATCHDOG_CYCLES, runs_checked, NUM_RUNS));
    end

    initial begin : main_proc
        arst_n_i  = 1'b0;
        start_i   = 1'b0;
        row_bar_i = '0;
        col_bar_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;

        @(negedge clk);
        check_value("busy_o", 32'(busy_o), 0);
        check_value("load_o", 32'(load_o), 0);
        check_value("done_o", 32'(done_o), 0);
        check_matrix(result_o, '0);
        @(posedge clk);
        #DRIVE_DELAY;

        run_matrix(1'b0, 1'b0);
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;

        // Full scale, then two random runs started in each done cycle
        run_matrix(1'b1, 1'b0);
        run_matrix(1'b0, 1'b0);
        run_matrix(1'b0, 1'b1);

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_matrix(result_o, last_expected);

        if (runs_checked == NUM_RUNS) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Only %0d of %0d runs reached done_o", runs_checked, NUM_RUNS);
            $display("Regression failed");
            $fatal(1, "Missing runs");
        end
    end

endmodule
